//--- drawAdapter.sv
`timescale 1ns/1ps
`include "lcdDraw_settings.svh"

module drawAdapter
    import drawPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,        // Low holds at loopStart.
    input  logic [31:0] newCount,
    input  logic [31:0] accCount,
    input  logic [1:0]  mode,
    output logic        frameDone, // One-cycle pulse per frame.
    output sdramWr_t    wr,
    output logic        wrReq,
    input  logic        wrDone
);

    typedef enum logic [2:0] {
        stepIdle,      // First cycle after reset.
        stepClear,
        stepBorder,
        stepLoopStart, // Frame loop entry.
        stepNewCnt,
        stepAccCnt,
        stepMode,
        stepFrameEnd
    } step_e;

    step_e    step;
    step_e    nextStep;
    logic     isCmdStep; // Step issues a drawCore command.
    logic     coreEn;
    logic     coreDone;
    drawReq_t stepReq;   // Request for the current step.
    drawReq_t req;       // Captured at command start.

    drawCore u_drawCore (
        .clk      (clk),
        .rst_n    (rst_n),
        .coreEn   (coreEn),
        .req      (req),
        .coreDone (coreDone),
        .wr       (wr),
        .wrReq    (wrReq),
        .wrDone   (wrDone)
    );

    //////////////////////////////////////////////////
    // Step table.
    //////////////////////////////////////////////////

    always_comb begin
        stepReq = '0;
        isCmdStep = 1'b1;
        nextStep = step;
        case (step)
            stepIdle: begin
                isCmdStep = 1'b0;
                nextStep = stepClear;
            end
            stepClear: begin
                stepReq.cmd = cmdClear;
                stepReq.arg.fill.color = `COLOR_BG; // Background fill.
                nextStep = stepBorder;
            end
            stepBorder: begin
                stepReq.cmd = cmdBorder;
                nextStep = stepLoopStart;
            end
            stepLoopStart: begin
                isCmdStep = 1'b0;
                nextStep = stepNewCnt;
            end
            stepNewCnt: begin
                stepReq.cmd = cmdCounterRow;
                stepReq.row = 4'(`ROW_NEW_CNT);
                stepReq.arg.raw = newCount;
                nextStep = stepAccCnt;
            end
            stepAccCnt: begin
                stepReq.cmd = cmdCounterRow;
                stepReq.row = 4'(`ROW_ACC_CNT);
                stepReq.arg.raw = accCount;
                nextStep = stepMode;
            end
            stepMode: begin
                stepReq.cmd = cmdModeRow;
                stepReq.row = 4'(`ROW_MODE);
                stepReq.arg.raw = {30'd0, mode};
                nextStep = stepFrameEnd;
            end
            default: begin // stepFrameEnd.
                isCmdStep = 1'b0;
                nextStep = stepLoopStart;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Sequencer.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= stepIdle;
            coreEn <= 1'b0;
        end else if (isCmdStep) begin
            if (coreDone) begin
                coreEn <= 1'b0; // Drop with the done pulse.
                step <= nextStep;
            end else if (!coreEn && en) begin
                coreEn <= 1'b1; // No new command while en is low.
            end
        end else if (en || step == stepFrameEnd) begin
            step <= nextStep;
        end
    end

    // Arguments frozen for the whole command.
    always_ff @(posedge clk) begin
        if (isCmdStep && !coreEn && en)
            req <= stepReq;
    end

    assign frameDone = (step == stepFrameEnd);

endmodule

//--- drawCore.sv
`timescale 1ns/1ps
`include "lcdDraw_settings.svh"

module drawCore
    import drawPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     coreEn,   // Held high until coreDone.
    input  drawReq_t req,      // Stable while coreEn is high.
    output logic     coreDone, // One-cycle pulse.
    output sdramWr_t wr,       // Held while wrReq is high.
    output logic     wrReq,
    input  logic     wrDone    // One-cycle pulse from SDRAM side.
);

    localparam int PixPerWord = `SCREEN_W / `WORDS_PER_ROW;
    localparam logic [3:0] LastWord = 4'(`WORDS_PER_ROW - 1);
    localparam logic [3:0] LastRow = 4'(`SCREEN_H - 1);

    typedef enum logic [1:0] {
        sIdle, // Waiting for coreEn.
        sLoad, // Build word, raise wrReq.
        sWait, // Holding request until wrDone.
        sDone  // Report completion.
    } coreState_e;

    coreState_e state;
    logic [3:0] wordIdx;  // Word within the row.
    logic [3:0] rowIdx;   // Screen row.
    logic       lastWord; // Current word ends the command.
    logic [2:0] digitSel; // Hex digit index, 7 is most significant.
    logic [3:0] digit;
    sdramWr_t   nextWr;

    //////////////////////////////////////////////////
    // Word builder.
    //////////////////////////////////////////////////

    // Word 0 shows the top digit.
    assign digitSel = 3'd7 - wordIdx[2:0];
    assign digit = req.arg.raw[{digitSel, 2'b00} +: 4];

    always_comb begin
        case (req.cmd)
            cmdCounterRow: lastWord = (wordIdx == 4'd7); // Eight digits.
            cmdModeRow:    lastWord = (wordIdx == 4'd3); // Four cells.
            default:       lastWord = (wordIdx == LastWord) && (rowIdx == LastRow);
        endcase
    end

    always_comb begin
        // Linear word address in the low bits.
        nextWr.addr = 24'(rowIdx) * 24'(`WORDS_PER_ROW) + 24'(wordIdx);
        for (int k = 0; k < PixPerWord; k++) begin
            case (req.cmd)
                cmdClear: nextWr.data[k] = req.arg.fill.color;
                cmdBorder: nextWr.data[k] = `COLOR_BORDER;
                cmdCounterRow: nextWr.data[k] = digit[k] ? `COLOR_FG : `COLOR_BG;
                default: begin
                    // Selected mode cell lit.
                    nextWr.data[k] = (wordIdx[1:0] == req.arg.raw[1:0]) ?
                                     `COLOR_FG : `COLOR_BG;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Write sequencer.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sIdle;
            wordIdx <= '0;
            rowIdx <= '0;
            wrReq <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (coreEn) begin
                        wordIdx <= '0;
                        // Row commands start on their own row.
                        if (req.cmd == cmdCounterRow || req.cmd == cmdModeRow)
                            rowIdx <= req.row;
                        else
                            rowIdx <= '0;
                        state <= sLoad;
                    end
                end
                sLoad: begin
                    wrReq <= 1'b1; // wr loads on the same edge.
                    state <= sWait;
                end
                sWait: begin
                    if (wrDone) begin
                        wrReq <= 1'b0;
                        if (lastWord) begin
                            state <= sDone;
                        end else begin
                            state <= sLoad; // At least one low cycle.
                            wordIdx <= wordIdx + 4'd1;
                            if (wordIdx == LastWord) begin
                                // Border jumps straight to the bottom row.
                                rowIdx <= (req.cmd == cmdBorder) ? LastRow : rowIdx + 4'd1;
                            end
                        end
                    end
                end
                default: state <= sIdle; // sDone lasts one cycle.
            endcase
        end
    end

    // Payload register, loaded once per word.
    always_ff @(posedge clk) begin
        if (state == sLoad)
            wr <= nextWr;
    end

    assign coreDone = (state == sDone);

endmodule

//--- drawPkg.sv
package drawPkg;

    // Commands understood by drawCore.
    typedef enum logic [2:0] {
        cmdClear,      // Whole screen in one colour.
        cmdBorder,     // Top and bottom rows.
        cmdCounterRow, // Eight hex digits.
        cmdModeRow     // Mode marker, four cells.
    } drawCmd_e;

    // Fill colour view of the argument.
    typedef struct packed {
        logic [15:0] pad;
        logic [15:0] color; // RGB565.
    } drawFill_t;

    // Argument word, counter or colour depending on the command.
    typedef union packed {
        logic [31:0] raw;
        drawFill_t   fill;
    } drawArg_u;

    // One draw request, 39 bits.
    typedef struct packed {
        drawCmd_e   cmd;
        logic [3:0] row; // Target row for row commands.
        drawArg_u   arg;
    } drawReq_t;

    // SDRAM word write.
    typedef struct packed {
        logic [23:0]      addr; // Bank(2) + row(13) + column(9).
        logic [3:0][15:0] data; // Pixel k in data[k].
    } sdramWr_t;

endpackage

//--- flist.f
+incdir+.
drawPkg.sv
pulseAccumulator.sv
drawCore.sv
drawAdapter.sv
lcdDrawTop.sv
frameBufferModel.sv
tbLcdDraw.sv

//--- frameBufferModel.sv
`timescale 1ns/1ps

module frameBufferModel
    import drawPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  sdramWr_t wr,
    input  logic     wrReq,
    output logic     wrDone,     // One-cycle pulse per accepted word.
    output logic     wrChanged,  // Sticky, payload moved mid-request.
    output logic     reqOverlap  // Sticky, request held past its done.
);

    logic [63:0] mem [256]; // One entry per SDRAM word.
    sdramWr_t    held;
    logic        busy;
    logic        justDone;
    int          delay;

    initial begin
        wrDone = 1'b0;
        wrChanged = 1'b0;
        reqOverlap = 1'b0;
        busy = 1'b0;
        justDone = 1'b0;
        // Fill tied to the full address.
        for (int i = 0; i < 256; i++)
            mem[i] = {16'hDEAD, 16'hBEEF, 16'(i), ~16'(i)};
        forever begin
            @(posedge clk);
            #5;
            wrDone = 1'b0;
            if (!rst_n) begin
                busy = 1'b0;
                justDone = 1'b0;
            end else if (justDone) begin
                if (wrReq)
                    reqOverlap = 1'b1; // Request not released after done.
                justDone = 1'b0;
            end else if (busy) begin
                if (wr != held)
                    wrChanged = 1'b1;
                delay--;
                if (delay == 0) begin
                    mem[held.addr[7:0]] = held.data;
                    wrDone = 1'b1;
                    busy = 1'b0;
                    justDone = 1'b1;
                end
            end else if (wrReq) begin
                held = wr; // Latch new request.
                busy = 1'b1;
                delay = $urandom_range(6, 1);
            end
        end
    end

endmodule

//--- lcdDrawTop.sv
`timescale 1ns/1ps

module lcdDrawTop
    import drawPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        dataUpdate, // Pulse count strobe.
    input  logic [31:0] pulseCount,
    input  logic [1:0]  mode,       // Active mode 0..3.
    input  logic        wrDone,
    output sdramWr_t    wr,
    output logic        wrReq,
    output logic        frameDone
);

    logic [31:0] newCount;
    logic [31:0] accCount;

    // Counter capture.
    pulseAccumulator u_pulseAccumulator (
        .clk        (clk),
        .rst_n      (rst_n),
        .dataUpdate (dataUpdate),
        .pulseCount (pulseCount),
        .newCount   (newCount),
        .accCount   (accCount)
    );

    // Draw sequencing and SDRAM writes.
    drawAdapter u_drawAdapter (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .newCount  (newCount),
        .accCount  (accCount),
        .mode      (mode),
        .frameDone (frameDone),
        .wr        (wr),
        .wrReq     (wrReq),
        .wrDone    (wrDone)
    );

endmodule

//--- lcdDraw_settings.svh
`ifndef LCDDRAW_SETTINGS_SVH
`define LCDDRAW_SETTINGS_SVH

// Screen size in pixels.
`define SCREEN_W 64
`define SCREEN_H 16

// Four RGB565 pixels per 64-bit SDRAM word.
`define WORDS_PER_ROW 16

// Rows used by the periodic draws.
`define ROW_NEW_CNT 4 // Newest pulse count.
`define ROW_ACC_CNT 8 // Accumulated pulse count.
`define ROW_MODE 12 // Active-mode marker.

// RGB565 colours.
`define COLOR_BG 16'h0841 // Dark grey.
`define COLOR_FG 16'hFFE0 // Yellow.
`define COLOR_BORDER 16'hF800 // Red.

`endif

//--- pulseAccumulator.sv
`timescale 1ns/1ps

module pulseAccumulator (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dataUpdate, // New count valid.
    input  logic [31:0] pulseCount,
    output logic [31:0] newCount,   // Latest count.
    output logic [31:0] accCount    // Running sum.
);

    //////////////////////////////////////////////////
    // Lock-in register and running sum.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            newCount <= '0;
            accCount <= '0;
        end else if (dataUpdate) begin
            newCount <= pulseCount;
            // Wraps modulo 2^32.
            accCount <= accCount + pulseCount;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tbLcdDraw -o tbLcdDraw

# A failing run is judged by the log below.
./obj_dir/tbLcdDraw > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log

//--- tbLcdDraw.sv
`timescale 1ns/1ps
`include "lcdDraw_settings.svh"

module tbLcdDraw
    import drawPkg::*;
();

    localparam int Rounds = 20;
    localparam int WatchdogNs = Rounds * 300 * 8 * 100; // Rounds x words x cycles x period.

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        dataUpdate;
    logic [31:0] pulseCount;
    logic [1:0]  mode;
    logic        wrDone;
    logic        wrReq;
    logic        frameDone;
    logic        wrChanged;
    logic        reqOverlap;
    sdramWr_t    wr;
    logic [31:0] modelNew; // Reference state.
    logic [31:0] modelAcc; // Wraps like the DUT sum.
    logic [1:0]  modelMode;

    lcdDrawTop u_lcdDrawTop (
        .clk(clk), .rst_n(rst_n), .en(en), .dataUpdate(dataUpdate),
        .pulseCount(pulseCount), .mode(mode), .wrDone(wrDone),
        .wr(wr), .wrReq(wrReq), .frameDone(frameDone)
    );

    frameBufferModel u_frameBufferModel (
        .clk(clk), .rst_n(rst_n), .wr(wr), .wrReq(wrReq), .wrDone(wrDone),
        .wrChanged(wrChanged), .reqOverlap(reqOverlap)
    );

    //////////////////////////////////////////////////
    // Reporting and reference model.
    //////////////////////////////////////////////////

    task automatic failValue(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("error %s: expected %h, actual %h", name, exp, act);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic failText(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic string rowName(input int row);
        if (row == 0 || row == `SCREEN_H - 1) return "border";
        if (row == `ROW_NEW_CNT) return "newCount";
        if (row == `ROW_ACC_CNT) return "accCount";
        if (row == `ROW_MODE) return "modeRow";
        return "clear";
    endfunction

    // Expected word from the drawing rules.
    function automatic logic [63:0] expectedWord(input int row, input int w);
        logic [3:0][15:0] d;
        logic [3:0]       nib;
        d = {4{`COLOR_BG}};
        if (row == 0 || row == `SCREEN_H - 1) begin
            d = {4{`COLOR_BORDER}};
        end else if ((row == `ROW_NEW_CNT || row == `ROW_ACC_CNT) && w < 8) begin
            nib = 4'(((row == `ROW_NEW_CNT) ? modelNew : modelAcc) >> (4 * (7 - w)));
            for (int k = 0; k < 4; k++)
                d[k] = nib[k] ? `COLOR_FG : `COLOR_BG; // Bit k lights pixel k.
        end else if (row == `ROW_MODE && w < 4) begin
            d = {4{(w == int'(modelMode)) ? `COLOR_FG : `COLOR_BG}};
        end
        return d;
    endfunction

    task automatic checkFrame(input int round);
        logic [63:0] exp;
        logic [63:0] got;
        for (int r = 0; r < `SCREEN_H; r++) begin
            for (int w = 0; w < `WORDS_PER_ROW; w++) begin
                exp = expectedWord(r, w);
                got = u_frameBufferModel.mem[r * `WORDS_PER_ROW + w];
                assert (got == exp) else
                    failValue($sformatf("%s round %0d row %0d word %0d", rowName(r), round, r, w),
                              exp, got);
            end
        end
    endtask

    task automatic waitFrameDone();
        do @(negedge clk); while (!frameDone); // Sampled mid-cycle.
    endtask

    //////////////////////////////////////////////////
    // Clock, protocol monitor and watchdog.
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        assert (!wrChanged) else failText("SDRAM payload changed while a request was pending");
        assert (!reqOverlap) else failText("SDRAM request overlapped a finished one");
        // Framebuffer words live in the low eight address bits.
        assert (!wrReq || wr.addr[23:8] == '0) else
            failValue("address high bits", 64'd0, 64'(wr.addr[23:8]));
    end

    initial begin
        #(WatchdogNs);
        failText("Timeout, frames stopped completing");
    end

    //////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////

    initial begin
        int nUpd;
        void'($urandom(18));
        rst_n = 1'b0;
        en = 1'b1;
        dataUpdate = 1'b0;
        pulseCount = '0;
        mode = '0;
        modelNew = '0;
        modelAcc = '0;
        modelMode = '0;
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        @(negedge clk);
        assert (!wrReq && !frameDone) else
            failValue("reset outputs", 64'd0, 64'({wrReq, frameDone}));
        waitFrameDone();
        checkFrame(0); // Clear, border and idle counters.
        for (int round = 1; round <= Rounds; round++) begin
            @(posedge clk);
            #5 en = 1'b0;
            repeat (5) @(posedge clk); // Settle at loopStart.
            #5;
            nUpd = $urandom_range(3, 0);
            for (int i = 0; i < nUpd; i++) begin
                dataUpdate = 1'b1;
                pulseCount = $urandom;
                modelNew = pulseCount;
                modelAcc = modelAcc + pulseCount;
                @(posedge clk);
                #5 dataUpdate = 1'b0;
            end
            mode = 2'($urandom);
            modelMode = mode;
            en = 1'b1;
            waitFrameDone();
            checkFrame(round);
        end
        $display("Regression passed");
        $finish;
    end

endmodule
